// ==== list.f ====
corebus_pkg.sv
corebus_request_arbiter.sv
corebus_order_fifo.sv
corebus_memory_slave.sv
corebus_response_demux.sv
corebus_subsystem.sv
tb_corebus_subsystem.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_corebus_subsystem
RTL_TOP    := corebus_subsystem
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_corebus_subsystem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus subsystem testbench
// random masters with response back-pressure, checked
// against a memory model and per-master response queues
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module tb_corebus_subsystem;
  import corebus_pkg::*;

  localparam int MASTERS    = 3;
  localparam int FIFO_DEPTH = 4;
  localparam int ADDR_RANGE = 8;
  localparam int TIMEOUT    = 200;

  logic                               i_clk;
  logic                               i_reset;
  logic [MASTERS-1:0]                 i_mcmd_valid;
  corebus_command_e [MASTERS-1:0]     i_mcmd;
  logic [MASTERS-1:0][ADDR_WIDTH-1:0] i_maddr;
  logic [MASTERS-1:0][DATA_WIDTH-1:0] i_mdata;
  logic [MASTERS-1:0]                 o_scmd_accept;
  logic [MASTERS-1:0]                 o_sresp_valid;
  logic [MASTERS-1:0]                 i_mresp_accept;
  corebus_response_e                  o_sresp;
  logic [DATA_WIDTH-1:0]              o_sdata;

  // reference memory and expected {resp, data} per master
  logic [DATA_WIDTH-1:0] model_mem [2 ** ADDR_WIDTH];
  logic [DATA_WIDTH:0]   expect_q [MASTERS][$];
  int                    accept_hist [$];
  logic [MASTERS-1:0]    accepted;
  int                    errors;
  int                    checks;
  int                    issue_pct;
  int                    accept_pct;
  logic                  fair_check;
  logic                  accept_seen;
  logic                  resp_seen;
  logic                  held;
  int                    held_m;
  logic [DATA_WIDTH:0]   held_value;
  string                 test_name;

  corebus_subsystem #(
    .MASTERS       (MASTERS         ),
    .SELECTOR_TYPE (SELECTOR_BINARY ),
    .FIFO_DEPTH    (FIFO_DEPTH      )
  ) dut (
    .i_clk          (i_clk          ),
    .i_reset        (i_reset        ),
    .i_mcmd_valid   (i_mcmd_valid   ),
    .i_mcmd         (i_mcmd         ),
    .i_maddr        (i_maddr        ),
    .i_mdata        (i_mdata        ),
    .o_scmd_accept  (o_scmd_accept  ),
    .o_sresp_valid  (o_sresp_valid  ),
    .i_mresp_accept (i_mresp_accept ),
    .o_sresp        (o_sresp        ),
    .o_sdata        (o_sdata        )
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus, 1 ns after the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    for (int m = 0; m < MASTERS; m++) begin
      // a master keeps its command until it was accepted
      if (accepted[m]) begin
        i_mcmd_valid[m] = 1'b0;
      end
      if (!i_mcmd_valid[m] && (int'($urandom_range(99)) < issue_pct)) begin
        i_mcmd_valid[m] = 1'b1;
        i_mcmd[m]       = ($urandom_range(1) == 1) ? CMD_WRITE : CMD_READ;
        i_maddr[m]      = ADDR_WIDTH'($urandom_range(ADDR_RANGE - 1));
        i_mdata[m]      = $urandom;
      end
      i_mresp_accept[m] = (int'($urandom_range(99)) < accept_pct);
    end
    accepted = '0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // observation at the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic observe_cycle();
    logic [MASTERS-1:0] window;
    logic [DATA_WIDTH:0] actual;
    @(negedge i_clk);
    accept_seen = 1'b0;
    resp_seen   = 1'b0;
    actual      = {o_sresp, o_sdata};
    for (int m = 0; m < MASTERS; m++) begin
      if (o_scmd_accept[m]) begin
        accepted[m] = 1'b1;
        accept_seen = 1'b1;
        // the model runs commands in accept order like the slave
        if (i_mcmd[m] == CMD_WRITE) begin
          model_mem[i_maddr[m]] = i_mdata[m];
          expect_q[m].push_back({RESP_WRITE_ACK, DATA_WIDTH'(0)});
        end else begin
          expect_q[m].push_back({RESP_READ_DATA, model_mem[i_maddr[m]]});
        end
        if (fair_check) begin
          accept_hist.push_back(m);
          if (accept_hist.size() >= MASTERS) begin
            window = '0;
            for (int k = accept_hist.size() - MASTERS; k < accept_hist.size(); k++) begin
              window[accept_hist[k]] = 1'b1;
            end
            checks++;
            assert (&window) else begin
              errors++;
              $display("ERR %s: accept window expected %b actual %b", test_name,
                       {MASTERS{1'b1}}, window);
            end
          end
        end
      end
    end
    checks++;
    assert ($onehot0(o_sresp_valid)) else begin
      errors++;
      $display("%s: more than one response valid at once (%b)", test_name, o_sresp_valid);
    end
    // a response that was not taken must wait unchanged
    if (held) begin
      checks++;
      assert (o_sresp_valid[held_m] && (actual == held_value)) else begin
        errors++;
        $display("ERR %s: held response master %0d expected %h actual %h", test_name,
                 held_m, held_value, actual);
      end
    end
    held = 1'b0;
    for (int m = 0; m < MASTERS; m++) begin
      if (o_sresp_valid[m]) begin
        resp_seen = 1'b1;
        checks++;
        assert (expect_q[m].size() > 0) else begin
          errors++;
          $display("%s: response to master %0d with nothing outstanding", test_name, m);
        end
        if (expect_q[m].size() > 0) begin
          if (i_mresp_accept[m]) begin
            checks++;
            assert (actual == expect_q[m][0]) else begin
              errors++;
              $display("ERR %s: master %0d response expected %h actual %h", test_name, m,
                       expect_q[m][0], actual);
            end
            void'(expect_q[m].pop_front());
          end else begin
            held       = 1'b1;
            held_m     = m;
            held_value = actual;
          end
        end
      end
    end
  endtask

  task automatic run_cycle();
    next_cycle();
    observe_cycle();
  endtask

  function automatic int outstanding();
    int total;
    total = 0;
    for (int m = 0; m < MASTERS; m++) begin
      total += expect_q[m].size();
    end
    return total;
  endfunction

  // stop new commands and take every response
  task automatic drain();
    int waited;
    issue_pct  = 0;
    accept_pct = 100;
    waited     = 0;
    while (((outstanding() > 0) || (i_mcmd_valid != '0)) && (waited < TIMEOUT)) begin
      run_cycle();
      waited++;
    end
    checks++;
    assert ((outstanding() == 0) && (i_mcmd_valid == '0)) else begin
      errors++;
      $display("%s: timeout while draining, %0d responses missing", test_name, outstanding());
    end
  endtask

  initial begin
    int waited;
    int latency;
    void'($urandom(91));
    i_reset        = 1'b1;
    i_mcmd_valid   = '0;
    i_maddr        = '0;
    i_mdata        = '0;
    i_mresp_accept = '0;
    for (int m = 0; m < MASTERS; m++) begin
      i_mcmd[m] = CMD_READ;
    end
    for (int a = 0; a < 2 ** ADDR_WIDTH; a++) begin
      model_mem[a] = '0;
    end
    accepted   = '0;
    errors     = 0;
    checks     = 0;
    issue_pct  = 0;
    accept_pct = 100;
    fair_check = 1'b0;
    held       = 1'b0;
    test_name  = "reset";
    repeat (8) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    @(negedge i_clk);
    checks++;
    assert ((o_scmd_accept == '0) && (o_sresp_valid == '0)) else begin
      errors++;
      $display("ERR %s: accept/valid expected 0 actual %b/%b", test_name,
               o_scmd_accept, o_sresp_valid);
    end

    // single read on an idle subsystem, memory still holds zero
    test_name = "latency";
    next_cycle();
    i_mcmd_valid[1] = 1'b1;
    i_mcmd[1]       = CMD_READ;
    i_maddr[1]      = ADDR_WIDTH'(5);
    observe_cycle();
    waited = 0;
    while (!accept_seen && (waited < TIMEOUT)) begin
      run_cycle();
      waited++;
    end
    checks++;
    assert (accept_seen) else begin
      errors++;
      $display("%s: read command was never accepted", test_name);
    end
    latency = 0;
    resp_seen = 1'b0;
    while (!resp_seen && (latency < TIMEOUT)) begin
      run_cycle();
      latency++;
    end
    checks++;
    assert (latency == 2) else begin
      errors++;
      $display("ERR %s: cycles to response expected 2 actual %0d", test_name, latency);
    end
    drain();

    test_name  = "fairness";
    issue_pct  = 100;
    fair_check = 1'b1;
    repeat (60) run_cycle();
    fair_check = 1'b0;
    drain();

    test_name  = "random";
    issue_pct  = 60;
    accept_pct = 65;
    repeat (800) run_cycle();
    drain();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== corebus_subsystem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus subsystem
// masters share one memory slave, responses go back
// to their issuing master in command order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module corebus_subsystem
  import corebus_pkg::*;
#(
  parameter int                MASTERS       = 3,
  parameter corebus_selector_e SELECTOR_TYPE = SELECTOR_BINARY,
  parameter int                FIFO_DEPTH    = 4
)(
  input  logic                               i_clk,
  input  logic                               i_reset,
  input  logic [MASTERS-1:0]                 i_mcmd_valid,
  input  corebus_command_e [MASTERS-1:0]     i_mcmd,
  input  logic [MASTERS-1:0][ADDR_WIDTH-1:0] i_maddr,
  input  logic [MASTERS-1:0][DATA_WIDTH-1:0] i_mdata,
  output logic [MASTERS-1:0]                 o_scmd_accept,
  output logic [MASTERS-1:0]                 o_sresp_valid,
  input  logic [MASTERS-1:0]                 i_mresp_accept,
  output corebus_response_e                  o_sresp,
  output logic [DATA_WIDTH-1:0]              o_sdata
);
  localparam int SELECT_WIDTH = calc_select_width(SELECTOR_TYPE, MASTERS);

  logic                    slave_cmd_valid;
  logic                    slave_cmd_accept;
  corebus_command_e        slave_cmd;
  logic [ADDR_WIDTH-1:0]   slave_addr;
  logic [DATA_WIDTH-1:0]   slave_data;
  logic                    slave_resp_valid;
  logic                    slave_resp_accept;
  corebus_response_e       slave_resp;
  logic [DATA_WIDTH-1:0]   slave_rdata;
  logic                    fifo_push;
  logic                    fifo_pop;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic [SELECT_WIDTH-1:0] grant_select;
  logic [SELECT_WIDTH-1:0] fifo_select;

  corebus_request_arbiter #(
    .MASTERS       (MASTERS       ),
    .SELECTOR_TYPE (SELECTOR_TYPE )
  ) u_arbiter (
    .i_clk          (i_clk            ),
    .i_reset        (i_reset          ),
    .i_mcmd_valid   (i_mcmd_valid     ),
    .i_mcmd         (i_mcmd           ),
    .i_maddr        (i_maddr          ),
    .i_mdata        (i_mdata          ),
    .o_scmd_accept  (o_scmd_accept    ),
    .o_cmd_valid    (slave_cmd_valid  ),
    .o_cmd          (slave_cmd        ),
    .o_addr         (slave_addr       ),
    .o_data         (slave_data       ),
    .i_cmd_accept   (slave_cmd_accept ),
    .i_fifo_full    (fifo_full        ),
    .o_fifo_push    (fifo_push        ),
    .o_grant_select (grant_select     )
  );

  corebus_order_fifo #(
    .MASTERS       (MASTERS       ),
    .SELECTOR_TYPE (SELECTOR_TYPE ),
    .FIFO_DEPTH    (FIFO_DEPTH    )
  ) u_order_fifo (
    .i_clk    (i_clk        ),
    .i_reset  (i_reset      ),
    .i_push   (fifo_push    ),
    .i_select (grant_select ),
    .o_full   (fifo_full    ),
    .i_pop    (fifo_pop     ),
    .o_select (fifo_select  ),
    .o_empty  (fifo_empty   )
  );

  corebus_memory_slave u_slave (
    .i_clk         (i_clk             ),
    .i_reset       (i_reset           ),
    .i_cmd_valid   (slave_cmd_valid   ),
    .o_cmd_accept  (slave_cmd_accept  ),
    .i_cmd         (slave_cmd         ),
    .i_addr        (slave_addr        ),
    .i_data        (slave_data        ),
    .o_resp_valid  (slave_resp_valid  ),
    .i_resp_accept (slave_resp_accept ),
    .o_resp        (slave_resp        ),
    .o_rdata       (slave_rdata       )
  );

  corebus_response_demux #(
    .MASTERS       (MASTERS       ),
    .SELECTOR_TYPE (SELECTOR_TYPE )
  ) u_demux (
    .i_select       (fifo_select       ),
    .i_select_valid (!fifo_empty       ),
    .i_sresp_valid  (slave_resp_valid  ),
    .o_mresp_accept (slave_resp_accept ),
    .i_sresp        (slave_resp        ),
    .i_sdata        (slave_rdata       ),
    .o_sresp_valid  (o_sresp_valid     ),
    .i_mresp_accept (i_mresp_accept    ),
    .o_sresp        (o_sresp           ),
    .o_sdata        (o_sdata           ),
    .o_pop          (fifo_pop          )
  );

endmodule

// ==== corebus_response_demux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus response demux
// steers the slave response valid to the selected
// master and returns that master's accept
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module corebus_response_demux
  import corebus_pkg::*;
#(
  parameter int                MASTERS       = 3,
  parameter corebus_selector_e SELECTOR_TYPE = SELECTOR_BINARY
)(
  input  logic [calc_select_width(SELECTOR_TYPE, MASTERS)-1:0] i_select,
  input  logic                                                 i_select_valid,
  input  logic                                                 i_sresp_valid,
  output logic                                                 o_mresp_accept,
  input  corebus_response_e                                    i_sresp,
  input  logic [DATA_WIDTH-1:0]                                i_sdata,
  output logic [MASTERS-1:0]                                   o_sresp_valid,
  input  logic [MASTERS-1:0]                                   i_mresp_accept,
  output corebus_response_e                                    o_sresp,
  output logic [DATA_WIDTH-1:0]                                o_sdata,
  output logic                                                 o_pop
);
  logic [MASTERS-1:0] select_onehot;
  logic               route_valid;

  // select decode, one bit per master either way
  if (SELECTOR_TYPE == SELECTOR_ONEHOT) begin : g_onehot_decode
    assign select_onehot = i_select;
  end else begin : g_binary_decode
    assign select_onehot = MASTERS'(1) << i_select;
  end

  // demux the valid, mux the accept back
  assign route_valid    = i_sresp_valid && i_select_valid;
  assign o_sresp_valid  = select_onehot & {MASTERS{route_valid}};
  assign o_mresp_accept = |(select_onehot & i_mresp_accept);

  // payload is shared, only the valid tells a master it is addressed
  assign o_sresp = i_sresp;
  assign o_sdata = i_sdata;

  // head of the order FIFO retires on each completed handshake
  assign o_pop = route_valid && o_mresp_accept;

  always_comb begin
    // every response from the slave has a recorded owner
    if (i_sresp_valid) begin
      assert final (i_select_valid);
    end
    // encoded select stays inside the master range
    if (i_select_valid) begin
      assert final ($countones(select_onehot) == 1);
    end
  end

endmodule

// ==== corebus_memory_slave.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus memory slave
// two-stage pipeline over a word memory, answers
// each read or write in order under back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module corebus_memory_slave
  import corebus_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_accept,
  input  corebus_command_e      i_cmd,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic                  o_resp_valid,
  input  logic                  i_resp_accept,
  output corebus_response_e     o_resp,
  output logic [DATA_WIDTH-1:0] o_rdata
);
  localparam int WORDS = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] memory [WORDS];

  // stage 1 holds the accepted command
  logic                  s1_valid;
  corebus_command_e      s1_cmd;
  logic [ADDR_WIDTH-1:0] s1_addr;
  logic [DATA_WIDTH-1:0] s1_data;
  logic                  s1_advance;

  // stage 2 holds the response until it is taken
  logic                  s2_valid;
  corebus_response_e     s2_resp;
  logic [DATA_WIDTH-1:0] s2_rdata;
  logic                  s2_ready;

  assign s2_ready     = !s2_valid || i_resp_accept;
  assign s1_advance   = s1_valid && s2_ready;
  assign o_cmd_accept = !s1_valid || s2_ready;

  assign o_resp_valid = s2_valid;
  assign o_resp       = s2_resp;
  assign o_rdata      = s2_rdata;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (o_cmd_accept) begin
        s1_valid <= i_cmd_valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cmd_valid && o_cmd_accept) begin
      s1_cmd  <= i_cmd;
      s1_addr <= i_addr;
      s1_data <= i_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory access in stage 2
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < WORDS; i++) begin
        memory[i] <= '0;
      end
    end else if (s1_advance && (s1_cmd == CMD_WRITE)) begin
      memory[s1_addr] <= s1_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s1_advance) begin
      if (s1_cmd == CMD_WRITE) begin
        s2_resp  <= RESP_WRITE_ACK;
        s2_rdata <= '0;
      end else begin
        s2_resp  <= RESP_READ_DATA;
        s2_rdata <= memory[s1_addr];
      end
    end
  end

endmodule

// ==== corebus_order_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus order FIFO
// keeps the master select of every outstanding
// command in the order the commands were issued
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module corebus_order_fifo
  import corebus_pkg::*;
#(
  parameter int                MASTERS       = 3,
  parameter corebus_selector_e SELECTOR_TYPE = SELECTOR_BINARY,
  parameter int                FIFO_DEPTH    = 4
)(
  input  logic                                                 i_clk,
  input  logic                                                 i_reset,
  input  logic                                                 i_push,
  input  logic [calc_select_width(SELECTOR_TYPE, MASTERS)-1:0] i_select,
  output logic                                                 o_full,
  input  logic                                                 i_pop,
  output logic [calc_select_width(SELECTOR_TYPE, MASTERS)-1:0] o_select,
  output logic                                                 o_empty
);
  localparam int SELECT_WIDTH = calc_select_width(SELECTOR_TYPE, MASTERS);
  localparam int PTR_WIDTH    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_WIDTH  = $clog2(FIFO_DEPTH + 1);

  logic [SELECT_WIDTH-1:0] entries [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]    wr_ptr;
  logic [PTR_WIDTH-1:0]    rd_ptr;
  logic [COUNT_WIDTH-1:0]  count;

  assign o_full   = (count == COUNT_WIDTH'(FIFO_DEPTH));
  assign o_empty  = (count == '0);
  assign o_select = entries[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      entries[wr_ptr] <= i_select;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (i_pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // the arbiter holds back at full, the demux only answers outstanding commands
  assert property (@(posedge i_clk) disable iff (i_reset) i_push |-> !o_full);
  assert property (@(posedge i_clk) disable iff (i_reset) i_pop |-> !o_empty);

endmodule

// ==== corebus_request_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus request arbiter
// round-robin choice among master commands, forwards
// the winner to the slave and records the grant
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module corebus_request_arbiter
  import corebus_pkg::*;
#(
  parameter int                MASTERS       = 3,
  parameter corebus_selector_e SELECTOR_TYPE = SELECTOR_BINARY
)(
  input  logic                                 i_clk,
  input  logic                                 i_reset,
  input  logic [MASTERS-1:0]                   i_mcmd_valid,
  input  corebus_command_e [MASTERS-1:0]       i_mcmd,
  input  logic [MASTERS-1:0][ADDR_WIDTH-1:0]   i_maddr,
  input  logic [MASTERS-1:0][DATA_WIDTH-1:0]   i_mdata,
  output logic [MASTERS-1:0]                   o_scmd_accept,
  output logic                                 o_cmd_valid,
  output corebus_command_e                     o_cmd,
  output logic [ADDR_WIDTH-1:0]                o_addr,
  output logic [DATA_WIDTH-1:0]                o_data,
  input  logic                                 i_cmd_accept,
  input  logic                                 i_fifo_full,
  output logic                                 o_fifo_push,
  output logic [calc_select_width(SELECTOR_TYPE, MASTERS)-1:0] o_grant_select
);
  localparam int INDEX_WIDTH  = calc_select_width(SELECTOR_BINARY, MASTERS);

  logic [INDEX_WIDTH-1:0] rr_ptr;
  logic [INDEX_WIDTH-1:0] grant_index;
  logic [MASTERS-1:0]     grant_onehot;
  logic                   grant_found;

  // first requesting master at or after the pointer
  always_comb begin : grant_search
    int candidate;
    grant_found = 1'b0;
    grant_index = '0;
    // walk downward so the closest master to the pointer wins
    for (int i = MASTERS - 1; i >= 0; i--) begin
      candidate = int'(rr_ptr) + i;
      if (candidate >= MASTERS) begin
        candidate = candidate - MASTERS;
      end
      if (i_mcmd_valid[candidate]) begin
        grant_found = 1'b1;
        grant_index = INDEX_WIDTH'(candidate);
      end
    end
    grant_onehot = grant_found ? (MASTERS'(1) << grant_index) : '0;
  end

  // no command goes out unless the order FIFO can record it
  assign o_cmd_valid   = grant_found && !i_fifo_full;
  assign o_cmd         = i_mcmd[grant_index];
  assign o_addr        = i_maddr[grant_index];
  assign o_data        = i_mdata[grant_index];
  assign o_fifo_push   = o_cmd_valid && i_cmd_accept;
  assign o_scmd_accept = grant_onehot & {MASTERS{o_fifo_push}};

  if (SELECTOR_TYPE == SELECTOR_ONEHOT) begin : g_onehot_select
    assign o_grant_select = grant_onehot;
  end else begin : g_binary_select
    assign o_grant_select = grant_index;
  end

  // pointer moves just past the master that was served
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rr_ptr <= '0;
    end else if (o_fifo_push) begin
      if (grant_index == INDEX_WIDTH'(MASTERS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_index + 1'b1;
      end
    end
  end

  // a master is accepted only while it requests, and never two at once
  assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0(o_scmd_accept) && ((o_scmd_accept & ~i_mcmd_valid) == '0));

endmodule

// ==== corebus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus package
// opcodes, select encodings and bus widths shared
// by the arbiter, order FIFO, slave and demux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package corebus_pkg;

  // word width and word-address width of the memory slave
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 6;

  // command opcode from a master
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } corebus_command_e;

  // response opcode from the slave
  typedef enum logic {
    RESP_READ_DATA = 1'b0,
    RESP_WRITE_ACK = 1'b1
  } corebus_response_e;

  // encoding of a master select
  typedef enum logic {
    SELECTOR_ONEHOT = 1'b0,
    SELECTOR_BINARY = 1'b1
  } corebus_selector_e;

  // one bit per entry for one-hot, an index of at least one bit for binary
  function automatic int calc_select_width(
    corebus_selector_e selector_type,
    int                entries
  );
    int width;
    if (selector_type == SELECTOR_ONEHOT) begin
      width = entries;
    end else if (entries > 1) begin
      width = $clog2(entries);
    end else begin
      width = 1;
    end
    return width;
  endfunction

endpackage
